/* sources.f */
+incdir+.
dram_pkg.sv
dram_cmd_queue.sv
dram_wdata_queue.sv
dram_sequencer.sv
dram_read_capture.sv
dram_controller.sv
tb_dram_model.sv
tb_dram_controller.sv

/* tb_dram_controller.sv */
// Testbench for the SDRAM controller: random user traffic checked against a reference memory.
`timescale 1ns/1ps
`include "dram_params.svh"

module tb_dram_controller;

  localparam int N_OPS     = 300;
  localparam int LIMIT_CYC = `DRAM_INIT_CYC + 100 + 200 * (N_OPS + 4);

  logic                    clk0;
  logic                    rst_n;
  logic                    app_cmd_valid;
  logic                    app_cmd_rnw;
  logic [`DRAM_ADDR_W-1:0] app_cmd_addr;
  logic [`DRAM_DQ_W-1:0]   app_wr_data;
  logic [`DRAM_BE_W-1:0]   app_wr_be;
  logic [`DRAM_DQ_W-1:0]   dram_dq_in;
  logic                    app_fifo_ready;
  logic [`DRAM_DQ_W-1:0]   app_rd_data;
  logic                    app_rd_valid;
  logic                    phy_rdy;
  logic                    dram_ras_n;
  logic                    dram_cas_n;
  logic                    dram_we_n;
  logic [`DRAM_BANK_W-1:0] dram_ba;
  logic [`DRAM_ROW_W-1:0]  dram_a;
  logic [`DRAM_DQ_W-1:0]   dram_dq_out;
  logic [`DRAM_BE_W-1:0]   dram_dm_n;
  logic                    dram_dq_oe;
  logic                    proto_err;
  logic                    init_done;
  int                      ref_total;

  logic [`DRAM_DQ_W-1:0]   ref_mem [int];
  logic [`DRAM_DQ_W-1:0]   exp_q [$];
  logic [`DRAM_ADDR_W-1:0] written [$];
  logic [31:0]             lcg_state;
  logic                    saw_not_ready;

  dram_controller uut (
    .clk0           (clk0),
    .rst_n          (rst_n),
    .app_cmd_valid  (app_cmd_valid),
    .app_cmd_rnw    (app_cmd_rnw),
    .app_cmd_addr   (app_cmd_addr),
    .app_wr_data    (app_wr_data),
    .app_wr_be      (app_wr_be),
    .dram_dq_in     (dram_dq_in),
    .app_fifo_ready (app_fifo_ready),
    .app_rd_data    (app_rd_data),
    .app_rd_valid   (app_rd_valid),
    .phy_rdy        (phy_rdy),
    .dram_ras_n     (dram_ras_n),
    .dram_cas_n     (dram_cas_n),
    .dram_we_n      (dram_we_n),
    .dram_ba        (dram_ba),
    .dram_a         (dram_a),
    .dram_dq_out    (dram_dq_out),
    .dram_dm_n      (dram_dm_n),
    .dram_dq_oe     (dram_dq_oe)
  );

  tb_dram_model mem_model (
    .clk0      (clk0),
    .rst_n     (rst_n),
    .ras_n     (dram_ras_n),
    .cas_n     (dram_cas_n),
    .we_n      (dram_we_n),
    .ba        (dram_ba),
    .a         (dram_a),
    .dq_out    (dram_dq_out),
    .dm_n      (dram_dm_n),
    .dq_oe     (dram_dq_oe),
    .dq_in     (dram_dq_in),
    .proto_err (proto_err),
    .init_done (init_done),
    .ref_total (ref_total)
  );

  initial begin
    clk0 = 1'b0;
    forever #5 clk0 = ~clk0;
  end

  // upper half of the LCG state, the low bits repeat too quickly.
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic logic [31:0] rand_word();
    return {next_rand(), next_rand()};
  endfunction

  function automatic logic [31:0] merge_bytes(input int k, input logic [31:0] data,
                                              input logic [3:0] be);
    logic [31:0] word;
    word = ref_mem.exists(k) ? ref_mem[k] : '0;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        word[8*i +: 8] = data[8*i +: 8];
      end
    end
    return word;
  endfunction

  task automatic check_eq(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR at %0t: %s, expected %h, got %h", $time, what, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic wait_ready();
    @(negedge clk0);
    while (!app_fifo_ready) begin
      @(negedge clk0);
    end
  endtask

  task automatic send_write(input logic [`DRAM_ADDR_W-1:0] addr, input logic [31:0] d0,
                            input logic [31:0] d1, input logic [3:0] be0, input logic [3:0] be1);
    wait_ready();
    @(posedge clk0);
    app_cmd_valid <= 1'b1;
    app_cmd_rnw   <= 1'b0;
    app_cmd_addr  <= addr;
    app_wr_data   <= d0;
    app_wr_be     <= be0;
    ref_mem[{addr, 1'b0}] = merge_bytes({addr, 1'b0}, d0, be0);
    ref_mem[{addr, 1'b1}] = merge_bytes({addr, 1'b1}, d1, be1);
    @(posedge clk0);
    app_cmd_valid <= 1'b0;
    app_wr_data   <= d1;
    app_wr_be     <= be1;
  endtask

  task automatic send_read(input logic [`DRAM_ADDR_W-1:0] addr);
    wait_ready();
    @(posedge clk0);
    app_cmd_valid <= 1'b1;
    app_cmd_rnw   <= 1'b1;
    app_cmd_addr  <= addr;
    exp_q.push_back(ref_mem[{addr, 1'b0}]);
    exp_q.push_back(ref_mem[{addr, 1'b1}]);
    @(posedge clk0);
    app_cmd_valid <= 1'b0;
  endtask

  // few rows per bank so that hits, misses and closed banks all occur.
  task automatic random_op();
    logic [15:0]             pick;
    logic [`DRAM_ADDR_W-1:0] addr;
    logic [3:0]              be0;
    logic [3:0]              be1;
    pick = next_rand();
    if (written.size() != 0 && pick[0]) begin
      send_read(written[next_rand() % written.size()]);
    end else begin
      addr = {`DRAM_ROW_W'(next_rand() % 3), `DRAM_BANK_W'(next_rand() % 4),
              `DRAM_COL_W'(next_rand() % 8)};
      be0  = 4'(next_rand());
      be1  = 4'(next_rand());
      if (!ref_mem.exists({addr, 1'b0})) begin
        be0 = 4'hf;
        be1 = 4'hf;
        written.push_back(addr);
      end
      send_write(addr, rand_word(), rand_word(), be0, be1);
    end
  endtask

  always @(negedge clk0) begin
    if (rst_n && app_rd_valid) begin
      check_eq("read beat with none outstanding", 1, exp_q.size() != 0);
      check_eq("read data", exp_q[0], app_rd_data);
      exp_q.delete(0);
    end
    if (rst_n && phy_rdy && !app_fifo_ready) begin
      saw_not_ready <= 1'b1;
    end
  end

  always @(negedge clk0) begin
    if (proto_err) begin
      $display("Test failures found");
      $fatal(1, "memory model saw a protocol violation");
    end
  end

  initial begin
    repeat (LIMIT_CYC) @(posedge clk0);
    $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYC);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_n         = 1'b0;
    app_cmd_valid = 1'b0;
    app_cmd_rnw   = 1'b0;
    app_cmd_addr  = '0;
    app_wr_data   = '0;
    app_wr_be     = '0;
    lcg_state     = 32'ha402d461;
    saw_not_ready = 1'b0;
    repeat (7) @(posedge clk0);
    @(negedge clk0);
    check_eq("ras/cas/we in reset", 3'b111, {dram_ras_n, dram_cas_n, dram_we_n});
    check_eq("dq_oe in reset", 0, dram_dq_oe);
    check_eq("app_rd_valid in reset", 0, app_rd_valid);
    check_eq("phy_rdy in reset", 0, phy_rdy);
    @(posedge clk0);
    rst_n <= 1'b1;

    // this write is queued before init completes.
    send_write({12'd5, 2'd1, 8'd3}, 32'h11223344, 32'h55667788, 4'hf, 4'hf);
    @(negedge clk0);
    while (!phy_rdy) begin
      @(negedge clk0);
    end
    check_eq("init sequence seen by model before phy_rdy", 1, init_done);

    send_read({12'd5, 2'd1, 8'd3});
    send_write({12'd5, 2'd1, 8'd3}, 32'haabbccdd, 32'h99eeff00, 4'b0101, 4'b1010);
    send_read({12'd5, 2'd1, 8'd3});
    written.push_back({12'd5, 2'd1, 8'd3});

    for (int i = 0; i < N_OPS; i++) begin
      random_op();
      // the second half runs back to back to fill the queues.
      if (i < N_OPS / 2) begin
        repeat (next_rand() % 4) @(posedge clk0);
      end
    end

    @(negedge clk0);
    while (exp_q.size() != 0) begin
      @(negedge clk0);
    end
    repeat (20) @(negedge clk0);
    check_eq("app_fifo_ready fell during bursts", 1, saw_not_ready);
    check_eq("periodic refreshes seen", 1, ref_total >= 3);
    $display("All tests passed!");
    $finish;
  end

endmodule

/* tb_dram_model.sv */
// Behavioral SDRAM for the testbench: checks command legality and timing, stores writes and returns reads.
`timescale 1ns/1ps
`include "dram_params.svh"

module tb_dram_model (
  input  logic                    clk0,
  input  logic                    rst_n,
  input  logic                    ras_n,
  input  logic                    cas_n,
  input  logic                    we_n,
  input  logic [`DRAM_BANK_W-1:0] ba,
  input  logic [`DRAM_ROW_W-1:0]  a,
  input  logic [`DRAM_DQ_W-1:0]   dq_out,
  input  logic [`DRAM_BE_W-1:0]   dm_n,
  input  logic                    dq_oe,
  output logic [`DRAM_DQ_W-1:0]   dq_in,
  output logic                    proto_err,
  output logic                    init_done,
  output int                      ref_total
);

  localparam int NBANK = 1 << `DRAM_BANK_W;
  // longest command sequence that can hold back a due refresh.
  localparam int MAX_CMD_CYC = 30;

  logic [`DRAM_DQ_W-1:0]  store [int];
  logic [`DRAM_DQ_W-1:0]  sched [int];
  logic [NBANK-1:0]       bank_open;
  logic [`DRAM_ROW_W-1:0] open_row [NBANK];
  int                     act_cyc [NBANK];
  int                     pre_cyc [NBANK];
  int                     cyc;
  int                     ref_cyc;
  int                     refs;
  int                     key;
  int                     wr_key;
  logic                   prea_seen;
  logic                   wr_next;

  // unwritten words read back as a pattern of their full address.
  function automatic logic [`DRAM_DQ_W-1:0] fetch(input int k);
    return store.exists(k) ? store[k] : ((32'(k) * 32'h9e3779b1) ^ 32'h0f0f0f0f);
  endfunction

  // dm_n low lets a byte through.
  task automatic write_beat(input int k);
    logic [`DRAM_DQ_W-1:0] word;
    word = fetch(k);
    for (int i = 0; i < `DRAM_BE_W; i++) begin
      if (!dm_n[i]) begin
        word[8*i +: 8] = dq_out[8*i +: 8];
      end
    end
    store[k] = word;
  endtask

  task automatic flag(input string msg);
    $display("DRAM model error at %0t: %s", $time, msg);
    proto_err <= 1'b1;
  endtask

  task automatic check_gap(input int since, input int need, input string what);
    if (cyc - since < need) begin
      flag({what, " came too soon"});
    end
  endtask

  always @(posedge clk0) begin
    if (!rst_n) begin
      cyc       = 0;
      ref_cyc   = -100;
      refs      = 0;
      bank_open = '0;
      prea_seen = 1'b0;
      wr_next   = 1'b0;
      for (int i = 0; i < NBANK; i++) begin
        act_cyc[i] = -100;
        pre_cyc[i] = -100;
      end
      sched.delete();
      dq_in     <= '0;
      proto_err <= 1'b0;
      init_done <= 1'b0;
      ref_total <= 0;
    end else begin
      cyc = cyc + 1;
      dq_in <= sched.exists(cyc) ? sched[cyc] : '0;
      sched.delete(cyc);
      if (wr_next) begin
        if (!dq_oe) begin
          flag("second write beat without dq_oe");
        end
        write_beat(wr_key);
        wr_next = 1'b0;
      end
      key = int'({open_row[ba], ba, a[`DRAM_COL_W-1:0], 1'b0});
      case ({ras_n, cas_n, we_n})
        3'b011: begin
          if (bank_open[ba]) begin
            flag($sformatf("ACT to bank %0d while it is already open", ba));
          end
          check_gap(pre_cyc[ba], `DRAM_TRP, "ACT after precharge");
          check_gap(ref_cyc, `DRAM_TRFC, "ACT after REF");
          bank_open[ba] = 1'b1;
          open_row[ba]  = a;
          act_cyc[ba]   = cyc;
        end
        3'b101, 3'b100: begin
          if (!bank_open[ba]) begin
            flag($sformatf("RD or WR to closed bank %0d", ba));
          end
          check_gap(act_cyc[ba], `DRAM_TRCD, "RD or WR after ACT");
          if (we_n) begin
            // first beat is driven so that it sits on the bus CAS_LAT cycles after RD.
            sched[cyc + `DRAM_CAS_LAT - 1] = fetch(key);
            sched[cyc + `DRAM_CAS_LAT]     = fetch(key + 1);
          end else begin
            if (!dq_oe) begin
              flag("first write beat without dq_oe");
            end
            write_beat(key);
            wr_next = 1'b1;
            wr_key  = key + 1;
          end
        end
        3'b010: begin
          if (a[10]) begin
            bank_open = '0;
            prea_seen = 1'b1;
            for (int i = 0; i < NBANK; i++) begin
              pre_cyc[i] = cyc;
            end
          end else begin
            bank_open[ba] = 1'b0;
            pre_cyc[ba]   = cyc;
          end
        end
        3'b001: begin
          if (bank_open != '0) begin
            flag("REF while a bank is still open");
          end
          for (int i = 0; i < NBANK; i++) begin
            check_gap(pre_cyc[i], `DRAM_TRP, "REF after precharge");
          end
          check_gap(ref_cyc, `DRAM_TRFC, "REF after REF");
          ref_cyc = cyc;
          refs    = refs + 1;
        end
        3'b111: begin
        end
        default: flag("unknown command on the ras/cas/we lines");
      endcase
      if (refs >= 2 && cyc - ref_cyc > `DRAM_REFI + MAX_CMD_CYC) begin
        flag("no REF within the refresh interval");
      end
      init_done <= prea_seen && (refs >= 2);
      ref_total <= refs;
    end
  end

endmodule

/* dram_controller.sv */
// Top of the SDRAM controller: user port, queues, sequencer, read capture and pin decode.
`timescale 1ns/1ps
`include "dram_params.svh"

module dram_controller (
  input  logic                    clk0,
  input  logic                    rst_n,
  input  logic                    app_cmd_valid,
  input  logic                    app_cmd_rnw,
  input  logic [`DRAM_ADDR_W-1:0] app_cmd_addr,
  input  logic [`DRAM_DQ_W-1:0]   app_wr_data,
  input  logic [`DRAM_BE_W-1:0]   app_wr_be,
  input  logic [`DRAM_DQ_W-1:0]   dram_dq_in,
  output logic                    app_fifo_ready,
  output logic [`DRAM_DQ_W-1:0]   app_rd_data,
  output logic                    app_rd_valid,
  output logic                    phy_rdy,
  output logic                    dram_ras_n,
  output logic                    dram_cas_n,
  output logic                    dram_we_n,
  output logic [`DRAM_BANK_W-1:0] dram_ba,
  output logic [`DRAM_ROW_W-1:0]  dram_a,
  output logic [`DRAM_DQ_W-1:0]   dram_dq_out,
  output logic [`DRAM_BE_W-1:0]   dram_dm_n,
  output logic                    dram_dq_oe
);

  dram_pkg::app_cmd_t  cmd_head;
  dram_pkg::wburst_t   wr_head;
  dram_pkg::dram_bus_t dram_bus;
  logic                cmd_valid;
  logic                wr_valid;
  logic                cmd_pop;
  logic                wr_pop;
  logic                cmd_afull;
  logic                wr_afull;
  logic                rd_issue;

  assign app_fifo_ready = !(cmd_afull || wr_afull);

  dram_cmd_queue u_cmd_queue (
    .clk0      (clk0),
    .rst_n     (rst_n),
    .push      (app_cmd_valid),
    .push_data ('{rnw: app_cmd_rnw, addr: app_cmd_addr}),
    .pop       (cmd_pop),
    .cmd_head  (cmd_head),
    .not_empty (cmd_valid),
    .afull     (cmd_afull)
  );

  dram_wdata_queue u_wdata_queue (
    .clk0      (clk0),
    .rst_n     (rst_n),
    .wr_cmd    (app_cmd_valid && !app_cmd_rnw),
    .wr_data   (app_wr_data),
    .wr_be     (app_wr_be),
    .pop       (wr_pop),
    .wr_head   (wr_head),
    .not_empty (wr_valid),
    .afull     (wr_afull)
  );

  dram_sequencer u_sequencer (
    .clk0      (clk0),
    .rst_n     (rst_n),
    .cmd_head  (cmd_head),
    .cmd_valid (cmd_valid),
    .wr_head   (wr_head),
    .wr_valid  (wr_valid),
    .cmd_pop   (cmd_pop),
    .wr_pop    (wr_pop),
    .rd_issue  (rd_issue),
    .dram_bus  (dram_bus),
    .phy_rdy   (phy_rdy)
  );

  dram_read_capture u_read_capture (
    .clk0         (clk0),
    .rst_n        (rst_n),
    .rd_issue     (rd_issue),
    .dram_dq_in   (dram_dq_in),
    .app_rd_data  (app_rd_data),
    .app_rd_valid (app_rd_valid)
  );

  // standard SDRAM truth table, A10 high selects all banks on precharge.
  always_comb begin
    dram_a = dram_bus.a;
    case (dram_bus.cmd)
      dram_pkg::ACT: {dram_ras_n, dram_cas_n, dram_we_n} = 3'b011;
      dram_pkg::RD:  {dram_ras_n, dram_cas_n, dram_we_n} = 3'b101;
      dram_pkg::WR:  {dram_ras_n, dram_cas_n, dram_we_n} = 3'b100;
      dram_pkg::PRE: {dram_ras_n, dram_cas_n, dram_we_n} = 3'b010;
      dram_pkg::PREA: begin
        {dram_ras_n, dram_cas_n, dram_we_n} = 3'b010;
        dram_a[10] = 1'b1;
      end
      dram_pkg::REF: {dram_ras_n, dram_cas_n, dram_we_n} = 3'b001;
      default:       {dram_ras_n, dram_cas_n, dram_we_n} = 3'b111;
    endcase
  end

  assign dram_ba     = dram_bus.ba;
  assign dram_dq_out = dram_bus.dq_out;
  assign dram_dm_n   = dram_bus.dm_n;
  assign dram_dq_oe  = dram_bus.dq_oe;

endmodule

/* dram_read_capture.sv */
// Read return path: times each RD by the CAS latency and hands both beats to the user.
`timescale 1ns/1ps
`include "dram_params.svh"

module dram_read_capture (
  input  logic                  clk0,
  input  logic                  rst_n,
  input  logic                  rd_issue,
  input  logic [`DRAM_DQ_W-1:0] dram_dq_in,
  output logic [`DRAM_DQ_W-1:0] app_rd_data,
  output logic                  app_rd_valid
);

  localparam int CL = `DRAM_CAS_LAT;

  // bit k is set k+1 cycles after an RD left the sequencer.
  logic [CL:0] rd_pipe;
  logic        beat_now;

  assign beat_now = rd_pipe[CL-1] || rd_pipe[CL];

  always_ff @(posedge clk0) begin
    if (!rst_n) begin
      rd_pipe      <= '0;
      app_rd_valid <= 1'b0;
    end else begin
      rd_pipe      <= {rd_pipe[CL-1:0], rd_issue};
      app_rd_valid <= beat_now;
    end
  end

  always_ff @(posedge clk0) begin
    if (beat_now) begin
      app_rd_data <= dram_dq_in;
    end
  end

  // back-to-back reads would overlap their beats on the data bus.
  assert property (@(posedge clk0) disable iff (!rst_n) rd_issue |=> !rd_issue);

endmodule

/* dram_sequencer.sv */
// Sequencer that runs SDRAM init and refresh, tracks open rows and issues commands for the top.
`timescale 1ns/1ps
`include "dram_params.svh"

module dram_sequencer (
  input  logic                clk0,
  input  logic                rst_n,
  input  dram_pkg::app_cmd_t  cmd_head,
  input  logic                cmd_valid,
  input  dram_pkg::wburst_t   wr_head,
  input  logic                wr_valid,
  output logic                cmd_pop,
  output logic                wr_pop,
  output logic                rd_issue,
  output dram_pkg::dram_bus_t dram_bus,
  output logic                phy_rdy
);

  localparam int WAIT_W = $clog2(`DRAM_INIT_CYC + 1);
  localparam int REF_W  = $clog2(`DRAM_REFI);
  localparam int NBANK  = 1 << `DRAM_BANK_W;
  localparam dram_pkg::dram_bus_t BUS_IDLE = '{cmd: dram_pkg::NOP, default: '0};

  dram_pkg::seq_state_e    state;
  logic [WAIT_W-1:0]       wait_cnt;
  logic [REF_W-1:0]        ref_cnt;
  logic                    ref_pend;
  logic                    init_ref2;
  logic                    pre_all;
  logic                    rd_gap;
  logic [NBANK-1:0]        bank_open;
  logic [`DRAM_ROW_W-1:0]  open_row [NBANK];
  logic [`DRAM_DQ_W-1:0]   beat1_data;
  logic [`DRAM_BE_W-1:0]   beat1_be;
  logic [`DRAM_COL_W-1:0]  head_col;
  logic [`DRAM_BANK_W-1:0] head_ba;
  logic [`DRAM_ROW_W-1:0]  head_row;
  logic                    idle_free;
  logic                    row_hit;
  logic                    issue_rw;
  logic                    pre_go;
  logic                    act_go;
  logic                    wait_done;
  logic                    ref_tick;

  assign {head_row, head_ba, head_col} = cmd_head.addr;

  // a write may only go out once its burst sits in the data queue.
  assign idle_free = (state == dram_pkg::IDLE) && !ref_pend && !rd_gap && cmd_valid;
  assign row_hit   = bank_open[head_ba] && (open_row[head_ba] == head_row);
  assign issue_rw  = idle_free && row_hit && (cmd_head.rnw || wr_valid);
  assign pre_go    = idle_free && bank_open[head_ba] && !row_hit;
  assign act_go    = idle_free && !bank_open[head_ba];
  assign cmd_pop   = issue_rw;
  assign wr_pop    = issue_rw && !cmd_head.rnw;
  assign wait_done = (wait_cnt == '0);
  assign ref_tick  = phy_rdy && (ref_cnt == REF_W'(`DRAM_REFI - 1));

  always_ff @(posedge clk0) begin
    if (!rst_n) begin
      ref_cnt <= '0;
    end else if (phy_rdy) begin
      ref_cnt <= ref_tick ? '0 : ref_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk0) begin
    if (act_go) begin
      open_row[head_ba] <= head_row;
    end
    if (issue_rw) begin
      beat1_data <= wr_head.data1;
      beat1_be   <= wr_head.be1;
    end
  end

  always_ff @(posedge clk0) begin
    if (!rst_n) begin
      state     <= dram_pkg::INIT_WAIT;
      wait_cnt  <= WAIT_W'(`DRAM_INIT_CYC - 1);
      ref_pend  <= 1'b0;
      init_ref2 <= 1'b0;
      pre_all   <= 1'b0;
      rd_gap    <= 1'b0;
      bank_open <= '0;
      phy_rdy   <= 1'b0;
      rd_issue  <= 1'b0;
      dram_bus  <= BUS_IDLE;
    end else begin
      dram_bus <= BUS_IDLE;
      rd_issue <= 1'b0;
      rd_gap   <= 1'b0;
      if (!wait_done) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      case (state)
        dram_pkg::INIT_WAIT: begin
          if (wait_done) begin
            dram_bus.cmd <= dram_pkg::PREA;
            wait_cnt     <= WAIT_W'(`DRAM_TRP - 1);
            state        <= dram_pkg::INIT_PREA;
          end
        end
        dram_pkg::INIT_PREA: begin
          if (wait_done) begin
            dram_bus.cmd <= dram_pkg::REF;
            wait_cnt     <= WAIT_W'(`DRAM_TRFC - 1);
            state        <= dram_pkg::INIT_REF;
          end
        end
        dram_pkg::INIT_REF: begin
          // two refreshes before the user traffic starts.
          if (wait_done && !init_ref2) begin
            dram_bus.cmd <= dram_pkg::REF;
            init_ref2    <= 1'b1;
            wait_cnt     <= WAIT_W'(`DRAM_TRFC - 1);
          end else if (wait_done) begin
            phy_rdy <= 1'b1;
            state   <= dram_pkg::IDLE;
          end
        end
        dram_pkg::IDLE: begin
          if (ref_pend && !rd_gap) begin
            dram_bus.cmd <= dram_pkg::PREA;
            pre_all      <= 1'b1;
            bank_open    <= '0;
            wait_cnt     <= WAIT_W'(`DRAM_TRP - 1);
            state        <= dram_pkg::PRE_WAIT;
          end else if (issue_rw && cmd_head.rnw) begin
            dram_bus.cmd <= dram_pkg::RD;
            dram_bus.ba  <= head_ba;
            dram_bus.a   <= `DRAM_ROW_W'(head_col);
            rd_issue     <= 1'b1;
            rd_gap       <= 1'b1;
          end else if (issue_rw) begin
            dram_bus.cmd    <= dram_pkg::WR;
            dram_bus.ba     <= head_ba;
            dram_bus.a      <= `DRAM_ROW_W'(head_col);
            dram_bus.dq_out <= wr_head.data0;
            dram_bus.dm_n   <= ~wr_head.be0;
            dram_bus.dq_oe  <= 1'b1;
            state           <= dram_pkg::WR_BEAT1;
          end else if (pre_go) begin
            dram_bus.cmd       <= dram_pkg::PRE;
            dram_bus.ba        <= head_ba;
            pre_all            <= 1'b0;
            bank_open[head_ba] <= 1'b0;
            wait_cnt           <= WAIT_W'(`DRAM_TRP - 1);
            state              <= dram_pkg::PRE_WAIT;
          end else if (act_go) begin
            dram_bus.cmd       <= dram_pkg::ACT;
            dram_bus.ba        <= head_ba;
            dram_bus.a         <= head_row;
            bank_open[head_ba] <= 1'b1;
            wait_cnt           <= WAIT_W'(`DRAM_TRCD - 1);
            state              <= dram_pkg::ACT_WAIT;
          end
        end
        dram_pkg::PRE_WAIT: begin
          // after a row miss, IDLE opens the new row.
          if (wait_done && pre_all) begin
            dram_bus.cmd <= dram_pkg::REF;
            ref_pend     <= 1'b0;
            wait_cnt     <= WAIT_W'(`DRAM_TRFC - 1);
            state        <= dram_pkg::REF_WAIT;
          end else if (wait_done) begin
            state <= dram_pkg::IDLE;
          end
        end
        dram_pkg::WR_BEAT1: begin
          dram_bus.dq_out <= beat1_data;
          dram_bus.dm_n   <= ~beat1_be;
          dram_bus.dq_oe  <= 1'b1;
          state           <= dram_pkg::IDLE;
        end
        default: begin
          if (wait_done) begin
            state <= dram_pkg::IDLE;
          end
        end
      endcase
      if (ref_tick) begin
        ref_pend <= 1'b1;
      end
    end
  end

  // column commands only reach a bank with an open row.
  assert property (@(posedge clk0) disable iff (!rst_n)
    (dram_bus.cmd inside {dram_pkg::RD, dram_pkg::WR}) |-> bank_open[dram_bus.ba]);

endmodule

/* dram_wdata_queue.sv */
// Write data FIFO that pairs the two beats of each write command into one burst entry.
`timescale 1ns/1ps
`include "dram_params.svh"

module dram_wdata_queue (
  input  logic                  clk0,
  input  logic                  rst_n,
  input  logic                  wr_cmd,
  input  logic [`DRAM_DQ_W-1:0] wr_data,
  input  logic [`DRAM_BE_W-1:0] wr_be,
  input  logic                  pop,
  output dram_pkg::wburst_t     wr_head,
  output logic                  not_empty,
  output logic                  afull
);

  localparam int PTR_W = $clog2(`DRAM_Q_DEPTH);

  dram_pkg::wburst_t     mem [`DRAM_Q_DEPTH];
  logic [PTR_W-1:0]      wptr;
  logic [PTR_W-1:0]      rptr;
  logic [PTR_W:0]        count;
  logic                  beat1_pend;
  logic [`DRAM_DQ_W-1:0] data0_q;
  logic [`DRAM_BE_W-1:0] be0_q;

  // beat 0 arrives with the command, beat 1 one cycle later.
  always_ff @(posedge clk0) begin
    if (wr_cmd) begin
      data0_q <= wr_data;
      be0_q   <= wr_be;
    end
    if (beat1_pend) begin
      mem[wptr] <= '{data1: wr_data, data0: data0_q, be1: wr_be, be0: be0_q};
    end
  end

  always_ff @(posedge clk0) begin
    if (!rst_n) begin
      beat1_pend <= 1'b0;
      wptr       <= '0;
      rptr       <= '0;
      count      <= '0;
    end else begin
      beat1_pend <= wr_cmd;
      if (beat1_pend) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({beat1_pend, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign wr_head   = mem[rptr];
  assign not_empty = (count != '0);
  assign afull     = (count >= (PTR_W + 1)'(`DRAM_Q_AFULL));

  // the cycle after a write belongs to its second beat.
  assert property (@(posedge clk0) disable iff (!rst_n) wr_cmd |=> !wr_cmd);

endmodule

/* dram_cmd_queue.sv */
// Command FIFO between the user port and the sequencer, with an almost-full flag for back-pressure.
`timescale 1ns/1ps
`include "dram_params.svh"

module dram_cmd_queue (
  input  logic               clk0,
  input  logic               rst_n,
  input  logic               push,
  input  dram_pkg::app_cmd_t push_data,
  input  logic               pop,
  output dram_pkg::app_cmd_t cmd_head,
  output logic               not_empty,
  output logic               afull
);

  localparam int PTR_W = $clog2(`DRAM_Q_DEPTH);

  dram_pkg::app_cmd_t mem [`DRAM_Q_DEPTH];
  logic [PTR_W-1:0]   wptr;
  logic [PTR_W-1:0]   rptr;
  logic [PTR_W:0]     count;

  always_ff @(posedge clk0) begin
    if (push) begin
      mem[wptr] <= push_data;
    end
  end

  // pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk0) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign cmd_head  = mem[rptr];
  assign not_empty = (count != '0);
  assign afull     = (count >= (PTR_W + 1)'(`DRAM_Q_AFULL));

  // the sequencer only pops a head it has seen.
  assert property (@(posedge clk0) disable iff (!rst_n) pop |-> not_empty);
  // the ready level keeps the user from overfilling the queue.
  assert property (@(posedge clk0) disable iff (!rst_n)
    push |-> (count != (PTR_W + 1)'(`DRAM_Q_DEPTH)));

endmodule

/* dram_pkg.sv */
// Shared opcode, state and bus types for the SDRAM controller and its testbench.
`include "dram_params.svh"

package dram_pkg;

  // memory opcode, decoded into ras_n/cas_n/we_n at the top.
  typedef enum logic [2:0] {
    NOP  = 3'd0,
    ACT  = 3'd1,
    RD   = 3'd2,
    WR   = 3'd3,
    PRE  = 3'd4,
    PREA = 3'd5,
    REF  = 3'd6
  } dram_cmd_e;

  // one user command as held in the command queue.
  typedef struct packed {
    logic                    rnw;
    logic [`DRAM_ADDR_W-1:0] addr;
  } app_cmd_t;

  // one write burst of two beats with their byte enables.
  typedef struct packed {
    logic [`DRAM_DQ_W-1:0] data1;
    logic [`DRAM_DQ_W-1:0] data0;
    logic [`DRAM_BE_W-1:0] be1;
    logic [`DRAM_BE_W-1:0] be0;
  } wburst_t;

  // registered pin-side command and write data.
  typedef struct packed {
    dram_cmd_e               cmd;
    logic [`DRAM_BANK_W-1:0] ba;
    logic [`DRAM_ROW_W-1:0]  a;
    logic [`DRAM_DQ_W-1:0]   dq_out;
    logic [`DRAM_BE_W-1:0]   dm_n;
    logic                    dq_oe;
  } dram_bus_t;

  typedef enum logic [2:0] {
    INIT_WAIT,
    INIT_PREA,
    INIT_REF,
    IDLE,
    PRE_WAIT,
    ACT_WAIT,
    WR_BEAT1,
    REF_WAIT
  } seq_state_e;

endpackage

/* dram_params.svh */
// Width, burst and timing constants for the SDRAM controller; include wherever sizes are needed.
`ifndef DRAM_PARAMS_SVH
`define DRAM_PARAMS_SVH

// data path.
`define DRAM_DQ_W      32
`define DRAM_BE_W      4

// address split: column low, then bank, then row.
`define DRAM_COL_W     8
`define DRAM_ROW_W     12
`define DRAM_BANK_W    2
`define DRAM_ADDR_W    22

// memory timing, all in clk0 cycles.
`define DRAM_CAS_LAT   5
`define DRAM_TRCD      3
`define DRAM_TRP       3
`define DRAM_TRFC      10
`define DRAM_REFI      400
`define DRAM_INIT_CYC  50

// command and write data queues.
`define DRAM_Q_DEPTH   8
`define DRAM_Q_AFULL   6

`endif
